/* Makefile */
TOP := tb_fir

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TEST OK" sim.log || { echo "no pass line in sim.log"; exit 1; }

clean:
	rm -rf obj_dir sim.log

/* bench/fir_sva.sv */
module fir_sva (
    input logic                   axis_clk,
    input logic                   axis_rst_n,
    input fir_pkg::engine_state_e state,
    input logic                   ss_tvalid,
    input logic                   ss_tlast,
    input logic                   ss_tready,
    input logic                   sm_tvalid,
    input fir_pkg::data_t         sm_tdata,
    input logic                   sm_tlast,
    input logic                   sm_tready,
    input logic                   run_done
);
    timeunit 1ns;
    timeprecision 1ps;
    import fir_pkg::*;

    // sample taken but its output not yet transferred
    logic in_flight;
    // tlast seen with the sample in flight
    logic last_in;

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            in_flight <= 1'b0;
            last_in   <= 1'b0;
        end else if (ss_tvalid && ss_tready) begin
            in_flight <= 1'b1;
            last_in   <= ss_tlast;
        end else if (sm_tvalid && sm_tready) begin
            in_flight <= 1'b0;
        end
    end

    // output held with stable data until the sink takes it
    a_out_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata))
        else $error("sm_tvalid dropped or sm_tdata changed before sm_tready");

    // input only accepted while waiting, never with an output owed
    a_in_ready: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        ss_tready |-> state == ST_WAIT_IN && !in_flight)
        else $error("ss_tready high outside ST_WAIT_IN or before the output transfer");

    a_done_last: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        run_done |-> sm_tvalid && sm_tready && sm_tlast && last_in)
        else $error("run_done without a tlast output transfer");

endmodule

bind fir_engine fir_sva u_sva (.*);

/* bench/tb_fir.sv */
module tb_fir;
    timeunit 1ns;
    timeprecision 1ps;
    import fir_pkg::*;

    localparam int NUM_TAPS       = 11;
    localparam int TIMEOUT_CYCLES = 1000;

    logic       axis_clk;
    logic       axis_rst_n;
    addr_t      awaddr;
    logic       awvalid;
    logic       awready;
    data_t      wdata;
    logic       wvalid;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
    logic       bready;
    addr_t      araddr;
    logic       arvalid;
    logic       arready;
    data_t      rdata;
    logic       rvalid;
    logic       rready;
    logic       ss_tvalid;
    data_t      ss_tdata;
    logic       ss_tlast;
    logic       ss_tready;
    logic       sm_tvalid;
    data_t      sm_tdata;
    logic       sm_tlast;
    logic       sm_tready;

    integer seed = 32'h646b_d3b5;
    int     errors = 0;
    int     checks = 0;
    bit     hung = 1'b0;
    data_t  coef_m [0:NUM_TAPS-1];
    data_t  samples [0:63];
    int     gaps [0:63];
    bit     ready_pat [0:255];
    data_t  exp_q [$];

    fir_top #(
        .NUM_TAPS (NUM_TAPS)
    ) uut (.*);

    initial begin
        axis_clk = 1'b0;
        forever #4 axis_clk = ~axis_clk;
    end

    // a stuck handshake ends the run here
    initial begin
        wait (hung);
        $display("TEST FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // checks and reporting
    //////////////////////////////////////////////////
    task automatic report_hang(input string what);
        $display("timeout after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
        errors++;
        hung = 1'b1;
    endtask

    task automatic check_value(input string what, input data_t got, input data_t exp);
        checks++;
        assert (got === exp) else begin
            $display("ERR %0t ns: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int mark);
        $display("test %s: %0d errors", name, errors - mark);
    endtask

    //////////////////////////////////////////////////
    // axi-lite host, entered and left 1 ns after an edge
    //////////////////////////////////////////////////
    task automatic axil_write(input addr_t addr, input data_t data, output logic [1:0] resp);
        int cnt;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        cnt     = 0;
        @(posedge axis_clk);
        while (!awready) begin
            if (cnt == TIMEOUT_CYCLES) report_hang("awready");
            cnt++;
            @(posedge axis_clk);
        end
        check_value("wready with awready", data_t'(wready), 32'h1);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        cnt     = 0;
        @(posedge axis_clk);
        while (!bvalid) begin
            if (cnt == TIMEOUT_CYCLES) report_hang("bvalid");
            cnt++;
            @(posedge axis_clk);
        end
        resp = bresp;
        #1;
        bready = 1'b0;
    endtask

    task automatic axil_read(input addr_t addr, output data_t data);
        int cnt;
        araddr  = addr;
        arvalid = 1'b1;
        cnt     = 0;
        @(posedge axis_clk);
        while (!arready) begin
            if (cnt == TIMEOUT_CYCLES) report_hang("arready");
            cnt++;
            @(posedge axis_clk);
        end
        #1;
        arvalid = 1'b0;
        rready  = 1'b1;
        cnt     = 0;
        @(posedge axis_clk);
        while (!rvalid) begin
            if (cnt == TIMEOUT_CYCLES) report_hang("rvalid");
            cnt++;
            @(posedge axis_clk);
        end
        data = rdata;
        #1;
        rready = 1'b0;
    endtask

    task automatic start_run();
        logic [1:0] resp;
        axil_write(AP_CTRL_ADDR, 32'h1, resp);
        check_value("start bresp", data_t'(resp), '0);
    endtask

    //////////////////////////////////////////////////
    // reference model and stream drivers
    //////////////////////////////////////////////////
    // history starts from zero at every start
    task automatic build_run(input int n, input bit flow);
        data_t hist [0:NUM_TAPS-1];
        data_t acc;
        for (int k = 0; k < NUM_TAPS; k++) begin
            hist[k] = '0;
        end
        exp_q.delete();
        for (int i = 0; i < n; i++) begin
            for (int k = NUM_TAPS - 1; k > 0; k--) begin
                hist[k] = hist[k-1];
            end
            hist[0]    = $random(seed);
            samples[i] = hist[0];
            gaps[i]    = flow ? ($random(seed) & 3) : 0;
            acc        = '0;
            for (int k = 0; k < NUM_TAPS; k++) begin
                acc = acc + coef_m[k] * hist[k];
            end
            exp_q.push_back(acc);
        end
        for (int j = 0; j < 256; j++) begin
            ready_pat[j] = flow ? (($random(seed) & 3) != 0) : 1'b1;
        end
    endtask

    task automatic send_samples(input int n);
        int cnt;
        for (int i = 0; i < n; i++) begin
            repeat (gaps[i]) begin
                @(posedge axis_clk);
                #1;
            end
            ss_tvalid = 1'b1;
            ss_tdata  = samples[i];
            ss_tlast  = (i == n - 1);
            cnt       = 0;
            @(posedge axis_clk);
            while (!ss_tready) begin
                if (cnt == TIMEOUT_CYCLES) report_hang("ss_tready");
                cnt++;
                @(posedge axis_clk);
            end
            #1;
            ss_tvalid = 1'b0;
            ss_tlast  = 1'b0;
        end
    endtask

    task automatic collect_outputs(input int n);
        int got;
        int cnt;
        int cyc;
        got = 0;
        cnt = 0;
        cyc = 0;
        while (got < n) begin
            sm_tready = ready_pat[cyc % 256];
            @(posedge axis_clk);
            if (sm_tvalid && sm_tready) begin
                check_value($sformatf("output %0d data", got), sm_tdata, exp_q[got]);
                check_value($sformatf("output %0d tlast", got), data_t'(sm_tlast),
                            data_t'(got == n - 1));
                got++;
                cnt = 0;
            end else begin
                if (cnt == TIMEOUT_CYCLES) report_hang("sm_tvalid");
                cnt++;
            end
            #1;
            cyc++;
        end
        sm_tready = 1'b1;
        // nothing left over after the last output
        @(posedge axis_clk);
        check_value("sm_tvalid after last output", data_t'(sm_tvalid), '0);
        #1;
    endtask

    task automatic run_stream(input int n, input bit flow);
        build_run(n, flow);
        fork
            send_samples(n);
            collect_outputs(n);
        join
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////
    initial begin
        logic [1:0] resp;
        data_t      rd;
        data_t      new_coef;
        int         mark;
        axis_rst_n = 1'b0;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        ss_tlast   = 1'b0;
        sm_tready  = 1'b0;
        repeat (10) @(posedge axis_clk);
        #1;
        axis_rst_n = 1'b1;

        mark = errors;
        axil_read(AP_CTRL_ADDR, rd);
        check_value("ctrl after reset", rd, 32'h4);
        axil_read(12'h010, rd);
        check_value("unmapped 0x010", rd, '0);
        axil_read(12'h100, rd);
        check_value("unmapped 0x100", rd, '0);
        end_test("1 reset state", mark);

        mark = errors;
        for (int k = 0; k < NUM_TAPS; k++) begin
            coef_m[k] = $random(seed);
            axil_write(COEF_BASE_ADDR + addr_t'(4 * k), coef_m[k], resp);
            check_value("coef bresp", data_t'(resp), '0);
        end
        for (int k = 0; k < NUM_TAPS; k++) begin
            axil_read(COEF_BASE_ADDR + addr_t'(4 * k), rd);
            check_value($sformatf("coef %0d readback", k), rd, coef_m[k]);
        end
        end_test("2 coefficient write and read", mark);

        mark = errors;
        start_run();
        run_stream(30, 1'b0);
        axil_read(AP_CTRL_ADDR, rd);
        check_value("ctrl after run", rd, 32'h6);
        end_test("3 plain run", mark);

        mark = errors;
        start_run();
        run_stream(30, 1'b1);
        axil_read(AP_CTRL_ADDR, rd);
        check_value("ctrl after run", rd, 32'h6);
        end_test("4 run with gaps and stalls", mark);

        // coefficient write while busy must be dropped
        mark = errors;
        start_run();
        new_coef = ~coef_m[3];
        axil_write(COEF_BASE_ADDR + addr_t'(12), new_coef, resp);
        check_value("busy coef bresp", data_t'(resp), '0);
        axil_read(COEF_BASE_ADDR + addr_t'(12), rd);
        check_value("busy coef readback", rd, coef_m[3]);
        run_stream(20, 1'b1);
        axil_read(AP_CTRL_ADDR, rd);
        check_value("ctrl after run", rd, 32'h6);
        end_test("5 coefficient locked while busy", mark);

        mark = errors;
        start_run();
        axil_read(AP_CTRL_ADDR, rd);
        check_value("ctrl after second start", rd, 32'h0);
        run_stream(15, 1'b1);
        axil_read(AP_CTRL_ADDR, rd);
        check_value("ctrl after run", rd, 32'h6);
        end_test("6 restart clears history", mark);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
rtl/fir_pkg.sv
rtl/fir_axil_regs.sv
rtl/fir_sample_buffer.sv
rtl/fir_engine.sv
rtl/fir_top.sv
bench/fir_sva.sv
bench/tb_fir.sv

/* rtl/fir_axil_regs.sv */
module fir_axil_regs #(
    parameter int NUM_TAPS = 11
) (
    input  logic             axis_clk,
    input  logic             axis_rst_n,
    // write address and data
    input  fir_pkg::addr_t   awaddr,
    input  logic             awvalid,
    output logic             awready,
    input  fir_pkg::data_t   wdata,
    input  logic             wvalid,
    output logic             wready,
    // write response
    output logic             bvalid,
    output logic [1:0]       bresp,
    input  logic             bready,
    // read
    input  fir_pkg::addr_t   araddr,
    input  logic             arvalid,
    output logic             arready,
    output fir_pkg::data_t   rdata,
    output logic             rvalid,
    input  logic             rready,
    // engine side
    output logic             ap_start,
    input  logic             run_done,
    input  fir_pkg::tap_idx_t coef_idx,
    output fir_pkg::data_t   coef
);
    import fir_pkg::*;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    logic  ap_done;
    logic  ap_idle;
    logic  wr_hs;
    logic  rd_hs;
    logic  start_req;
    data_t rd_word;
    data_t coef_q [0:NUM_TAPS-1];

    // aligned offset inside the coefficient window
    function automatic logic coef_hit(addr_t a);
        addr_t ofs;
        ofs = a - COEF_BASE_ADDR;
        return (a >= COEF_BASE_ADDR) && (ofs < addr_t'(4 * NUM_TAPS)) && (a[1:0] == 2'b00);
    endfunction

    function automatic tap_idx_t coef_slot(addr_t a);
        addr_t ofs;
        ofs = a - COEF_BASE_ADDR;
        return ofs[5:2];
    endfunction

    // aw and w accepted together
    assign wready    = awready;
    assign wr_hs     = awready && awvalid && wvalid;
    assign rd_hs     = arready && arvalid;
    assign bresp     = RESP_OKAY;
    assign start_req = wr_hs && (awaddr == AP_CTRL_ADDR) && wdata[0] && ap_idle;
    assign coef      = coef_q[coef_idx];

    //////////////////////////////////////////////////
    // handshakes and control bits
    //////////////////////////////////////////////////
    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            awready  <= 1'b0;
            bvalid   <= 1'b0;
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            ap_start <= 1'b0;
            ap_done  <= 1'b0;
            ap_idle  <= 1'b1;
        end else begin
            // single-cycle ready, never while a response is pending
            awready <= awvalid && wvalid && !bvalid && !awready;
            if (wr_hs) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end

            arready <= arvalid && !rvalid && !arready;
            if (rd_hs) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end

            ap_start <= start_req;
            if (run_done) begin
                ap_done <= 1'b1;
                ap_idle <= 1'b1;
            end
            if (start_req) begin
                ap_done <= 1'b0;
                ap_idle <= 1'b0;
            end
        end
    end

    // read mux, unmapped offsets give zero
    always_comb begin
        rd_word = '0;
        if (araddr == AP_CTRL_ADDR) begin
            rd_word = {{(DATA_WIDTH-3){1'b0}}, ap_idle, ap_done, 1'b0};
        end else if (coef_hit(araddr)) begin
            rd_word = coef_q[coef_slot(araddr)];
        end
    end

    always_ff @(posedge axis_clk) begin
        if (rd_hs) begin
            rdata <= rd_word;
        end
    end

    // coefficients locked while a run is busy
    always_ff @(posedge axis_clk) begin
        if (wr_hs && ap_idle && coef_hit(awaddr)) begin
            coef_q[coef_slot(awaddr)] <= wdata;
        end
    end

endmodule

/* rtl/fir_engine.sv */
module fir_engine #(
    parameter int NUM_TAPS = 11
) (
    input  logic              axis_clk,
    input  logic              axis_rst_n,
    // control
    input  logic              ap_start,
    output logic              run_done,
    // coefficient lookup
    output fir_pkg::tap_idx_t coef_idx,
    input  fir_pkg::data_t    coef,
    // sample history
    output logic              buf_clear,
    output logic              buf_wr_en,
    output fir_pkg::data_t    buf_wr_data,
    output fir_pkg::tap_idx_t buf_rd_age,
    input  fir_pkg::data_t    buf_rd_data,
    // stream in
    input  logic              ss_tvalid,
    input  fir_pkg::data_t    ss_tdata,
    input  logic              ss_tlast,
    output logic              ss_tready,
    // stream out
    output logic              sm_tvalid,
    output fir_pkg::data_t    sm_tdata,
    output logic              sm_tlast,
    input  logic              sm_tready
);
    import fir_pkg::*;

    localparam tap_idx_t LAST_TAP = tap_idx_t'(NUM_TAPS - 1);

    engine_state_e state;
    tap_idx_t      tap_cnt;
    // history write still owed for the sample just taken
    logic          wr_pend;
    // set by start, dropped after the tlast output
    logic          armed;
    logic          ss_hs;
    logic          sm_hs;
    data_t         sample_q;
    logic          last_q;
    data_t         acc;
    data_t         product;

    assign ss_tready = (state == ST_WAIT_IN) && armed;
    assign ss_hs     = ss_tvalid && ss_tready;
    assign sm_tvalid = (state == ST_OUT);
    assign sm_tlast  = sm_tvalid && last_q;
    assign sm_tdata  = acc;
    assign sm_hs     = sm_tvalid && sm_tready;
    assign run_done  = sm_hs && last_q;

    // tap index doubles as sample age and clear counter
    assign coef_idx    = tap_cnt;
    assign buf_rd_age  = tap_cnt;
    assign buf_clear   = (state == ST_CLEAR);
    assign buf_wr_en   = (state == ST_MAC) && wr_pend;
    assign buf_wr_data = sample_q;

    // low 32 bits, same for signed and unsigned
    assign product = coef * buf_rd_data;

    //////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////
    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            state   <= ST_WAIT_IN;
            tap_cnt <= '0;
            wr_pend <= 1'b0;
            armed   <= 1'b0;
        end else if (ap_start) begin
            state   <= ST_CLEAR;
            tap_cnt <= '0;
            wr_pend <= 1'b0;
            armed   <= 1'b1;
        end else begin
            case (state)
                ST_CLEAR: begin
                    if (tap_cnt == LAST_TAP) begin
                        state   <= ST_WAIT_IN;
                        tap_cnt <= '0;
                    end else begin
                        tap_cnt <= tap_cnt + 1'b1;
                    end
                end
                ST_WAIT_IN: begin
                    if (ss_hs) begin
                        state   <= ST_MAC;
                        wr_pend <= 1'b1;
                    end
                end
                ST_MAC: begin
                    if (wr_pend) begin
                        wr_pend <= 1'b0;
                    end else if (tap_cnt == LAST_TAP) begin
                        state   <= ST_OUT;
                        tap_cnt <= '0;
                    end else begin
                        tap_cnt <= tap_cnt + 1'b1;
                    end
                end
                ST_OUT: begin
                    // hold result until the sink takes it
                    if (sm_hs) begin
                        state <= ST_WAIT_IN;
                        if (last_q) begin
                            armed <= 1'b0;
                        end
                    end
                end
                default: begin
                    state <= ST_WAIT_IN;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////
    always_ff @(posedge axis_clk) begin
        if (ss_hs) begin
            sample_q <= ss_tdata;
            last_q   <= ss_tlast;
            acc      <= '0;
        end else if ((state == ST_MAC) && !wr_pend) begin
            acc <= acc + product;
        end
    end

endmodule

/* rtl/fir_pkg.sv */
package fir_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////
    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 12;

    // samples, coefficients, sums and bus data
    typedef logic [DATA_WIDTH-1:0] data_t;
    // axi-lite byte address
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    // tap index and sample age
    typedef logic [3:0] tap_idx_t;

    //////////////////////////////////////////////////
    // register map
    //////////////////////////////////////////////////
    // bit 0 start, bit 1 done, bit 2 idle
    localparam addr_t AP_CTRL_ADDR = 12'h000;
    // coefficient k at COEF_BASE_ADDR + 4k
    localparam addr_t COEF_BASE_ADDR = 12'h020;

    // engine states
    typedef enum logic [1:0] {
        ST_CLEAR,
        ST_WAIT_IN,
        ST_MAC,
        ST_OUT
    } engine_state_e;

endpackage

/* rtl/fir_sample_buffer.sv */
module fir_sample_buffer #(
    parameter int NUM_TAPS = 11
) (
    input  logic              axis_clk,
    input  logic              axis_rst_n,
    input  logic              buf_clear,
    input  logic              buf_wr_en,
    input  fir_pkg::data_t    buf_wr_data,
    input  fir_pkg::tap_idx_t buf_rd_age,
    output fir_pkg::data_t    buf_rd_data
);
    import fir_pkg::*;

    data_t      mem [0:NUM_TAPS-1];
    tap_idx_t   wr_ptr;
    tap_idx_t   clr_ptr;
    logic [4:0] rd_sum;
    logic [4:0] rd_slot;

    // newest sample sits just behind wr_ptr
    assign rd_sum      = {1'b0, wr_ptr} + 5'(NUM_TAPS - 1) - {1'b0, buf_rd_age};
    assign rd_slot     = (rd_sum >= 5'(NUM_TAPS)) ? rd_sum - 5'(NUM_TAPS) : rd_sum;
    assign buf_rd_data = mem[rd_slot[3:0]];

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            wr_ptr  <= '0;
            clr_ptr <= '0;
            for (int i = 0; i < NUM_TAPS; i++) begin
                mem[i] <= '0;
            end
        end else if (buf_clear) begin
            // one entry per cycle
            mem[clr_ptr] <= '0;
            clr_ptr      <= (clr_ptr == tap_idx_t'(NUM_TAPS - 1)) ? '0 : clr_ptr + 1'b1;
            wr_ptr       <= '0;
        end else begin
            clr_ptr <= '0;
            if (buf_wr_en) begin
                mem[wr_ptr] <= buf_wr_data;
                wr_ptr      <= (wr_ptr == tap_idx_t'(NUM_TAPS - 1)) ? '0 : wr_ptr + 1'b1;
            end
        end
    end

endmodule

/* rtl/fir_top.sv */
module fir_top #(
    parameter int NUM_TAPS = 11
) (
    input  logic           axis_clk,
    input  logic           axis_rst_n,
    // axi-lite write
    input  fir_pkg::addr_t awaddr,
    input  logic           awvalid,
    output logic           awready,
    input  fir_pkg::data_t wdata,
    input  logic           wvalid,
    output logic           wready,
    output logic           bvalid,
    output logic [1:0]     bresp,
    input  logic           bready,
    // axi-lite read
    input  fir_pkg::addr_t araddr,
    input  logic           arvalid,
    output logic           arready,
    output fir_pkg::data_t rdata,
    output logic           rvalid,
    input  logic           rready,
    // stream in
    input  logic           ss_tvalid,
    input  fir_pkg::data_t ss_tdata,
    input  logic           ss_tlast,
    output logic           ss_tready,
    // stream out
    output logic           sm_tvalid,
    output fir_pkg::data_t sm_tdata,
    output logic           sm_tlast,
    input  logic           sm_tready
);
    import fir_pkg::*;

    logic     ap_start;
    logic     run_done;
    tap_idx_t coef_idx;
    data_t    coef;
    logic     buf_clear;
    logic     buf_wr_en;
    data_t    buf_wr_data;
    tap_idx_t buf_rd_age;
    data_t    buf_rd_data;

    fir_axil_regs #(
        .NUM_TAPS (NUM_TAPS)
    ) u_regs (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wvalid     (wvalid),
        .wready     (wready),
        .bvalid     (bvalid),
        .bresp      (bresp),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rvalid     (rvalid),
        .rready     (rready),
        .ap_start   (ap_start),
        .run_done   (run_done),
        .coef_idx   (coef_idx),
        .coef       (coef)
    );

    fir_sample_buffer #(
        .NUM_TAPS (NUM_TAPS)
    ) u_buf (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .buf_clear   (buf_clear),
        .buf_wr_en   (buf_wr_en),
        .buf_wr_data (buf_wr_data),
        .buf_rd_age  (buf_rd_age),
        .buf_rd_data (buf_rd_data)
    );

    fir_engine #(
        .NUM_TAPS (NUM_TAPS)
    ) u_engine (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .ap_start    (ap_start),
        .run_done    (run_done),
        .coef_idx    (coef_idx),
        .coef        (coef),
        .buf_clear   (buf_clear),
        .buf_wr_en   (buf_wr_en),
        .buf_wr_data (buf_wr_data),
        .buf_rd_age  (buf_rd_age),
        .buf_rd_data (buf_rd_data),
        .ss_tvalid   (ss_tvalid),
        .ss_tdata    (ss_tdata),
        .ss_tlast    (ss_tlast),
        .ss_tready   (ss_tready),
        .sm_tvalid   (sm_tvalid),
        .sm_tdata    (sm_tdata),
        .sm_tlast    (sm_tlast),
        .sm_tready   (sm_tready)
    );

endmodule
